// File: include/fpcmp_params.svh
// Float compare unit constants
`ifndef FPCMP_PARAMS_SVH
`define FPCMP_PARAMS_SVH

// Configuration bus
`define FPCMP_ADDR_CTRL   2'd0
`define FPCMP_ADDR_STATUS 2'd1
`define FPCMP_CFG_W       8

// Predicate codes held in CTRL[2:0]
`define FPCMP_PRED_EQ 3'd0
`define FPCMP_PRED_NE 3'd1
`define FPCMP_PRED_LT 3'd2
`define FPCMP_PRED_LE 3'd3
`define FPCMP_PRED_GT 3'd4
`define FPCMP_PRED_GE 3'd5
`define FPCMP_PRED_UN 3'd6  // True when unordered
`define FPCMP_PRED_OR 3'd7  // True when ordered

// Default quiet NaN
`define FPCMP_CANON_NAN 32'h7FC00000

`endif

// File: source/fpcmp_pkg.sv
// Float compare unit types
`default_nettype none

package fpcmp_pkg;

    // One IEEE 754 binary32 value
    typedef logic [31:0] fp32_t;

    // One-hot operand class
    typedef logic [5:0] fp_class_t;

    // Compare predicate selector
    typedef logic [2:0] pred_sel_t;

    // Bit positions inside fp_class_t
    localparam int CLS_ZERO    = 0;
    localparam int CLS_SUBNORM = 1;
    localparam int CLS_NORMAL  = 2;
    localparam int CLS_INF     = 3;
    localparam int CLS_QNAN    = 4;
    localparam int CLS_SNAN    = 5;

endpackage

`default_nettype wire

// File: source/fp_classifier.sv
// Binary32 operand classifier
`timescale 1ns/1ps
`default_nettype none

module fp_classifier
    import fpcmp_pkg::*;
(
    input  fp32_t     operand,
    output fp_class_t op_class
);

    logic [7:0]  exp_f;
    logic [22:0] mant_f;
    logic        exp_zero;
    logic        exp_max;
    logic        mant_zero;

    assign exp_f  = operand[30:23];
    assign mant_f = operand[22:0];

    assign exp_zero  = (exp_f == 8'h00);
    assign exp_max   = (exp_f == 8'hFF);
    assign mant_zero = (mant_f == 23'h0);

    always_comb begin
        op_class = '0;
        op_class[CLS_ZERO]    = exp_zero && mant_zero;
        op_class[CLS_SUBNORM] = exp_zero && !mant_zero;
        op_class[CLS_NORMAL]  = !exp_zero && !exp_max;
        op_class[CLS_INF]     = exp_max && mant_zero;
        // Mantissa MSB set marks a quiet NaN
        op_class[CLS_QNAN]    = exp_max && mant_f[22];
        op_class[CLS_SNAN]    = exp_max && !mant_f[22] && !mant_zero;
    end

endmodule

`default_nettype wire

// File: source/fp_comparator.sv
// Binary32 compare with predicate select
`timescale 1ns/1ps
`default_nettype none

`include "fpcmp_params.svh"

module fp_comparator
    import fpcmp_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  fp32_t     fp_a,
    input  fp32_t     fp_b,
    input  fp_class_t a_class,
    input  fp_class_t b_class,
    input  pred_sel_t pred_sel,
    input  logic      signaling,
    output logic      out_valid,
    output logic      eq,
    output logic      gt,
    output logic      lt,
    output logic      unordered,
    output logic      pred_result,
    output logic      invalid_pulse
);

    logic a_sign;
    logic b_sign;
    logic a_nan;
    logic b_nan;
    logic unord_c;
    logic both_zero;
    logic exp_gt;
    logic exp_eq;
    logic mant_gt;
    logic mag_gt;
    logic mag_eq;
    logic eq_c;
    logic gt_c;
    logic lt_c;
    logic pred_c;
    logic invalid_c;

    assign a_sign = fp_a[31];
    assign b_sign = fp_b[31];

    // NaN tests now come from each operand's own class
    assign a_nan   = a_class[CLS_QNAN] | a_class[CLS_SNAN];
    assign b_nan   = b_class[CLS_QNAN] | b_class[CLS_SNAN];
    assign unord_c = a_nan | b_nan;

    assign both_zero = a_class[CLS_ZERO] & b_class[CLS_ZERO];

    assign exp_gt  = (fp_a[30:23] > fp_b[30:23]);
    assign exp_eq  = (fp_a[30:23] == fp_b[30:23]);
    assign mant_gt = (fp_a[22:0] > fp_b[22:0]);
    assign mag_gt  = exp_gt || (exp_eq && mant_gt);
    assign mag_eq  = (fp_a[30:0] == fp_b[30:0]);

    // Equal bits also cover like-signed infinities
    assign eq_c = !unord_c && (both_zero || (fp_a == fp_b));

    always_comb begin
        gt_c = 1'b0;
        if (!unord_c && !both_zero) begin
            if (a_sign != b_sign) begin
                gt_c = !a_sign;
            end else if (!mag_eq) begin
                gt_c = a_sign ? !mag_gt : mag_gt;  // Negatives order in reverse
            end
        end
    end

    assign lt_c = !unord_c && !eq_c && !gt_c;

    always_comb begin
        pred_c = 1'b0;
        case (pred_sel)
            `FPCMP_PRED_EQ: pred_c = eq_c;
            `FPCMP_PRED_NE: pred_c = !eq_c;       // True on NaN inputs
            `FPCMP_PRED_LT: pred_c = lt_c;
            `FPCMP_PRED_LE: pred_c = lt_c | eq_c;
            `FPCMP_PRED_GT: pred_c = gt_c;
            `FPCMP_PRED_GE: pred_c = gt_c | eq_c;
            `FPCMP_PRED_UN: pred_c = unord_c;
            `FPCMP_PRED_OR: pred_c = !unord_c;
            default:        pred_c = 1'b0;
        endcase
    end

    assign invalid_c = a_class[CLS_SNAN] | b_class[CLS_SNAN] | (signaling & unord_c);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid     <= 1'b0;
            invalid_pulse <= 1'b0;
        end else begin
            out_valid     <= in_valid;
            invalid_pulse <= in_valid & invalid_c;  // One cycle, lines up with out_valid
        end
    end

    // Flags hold their value on idle cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eq          <= 1'b0;
            gt          <= 1'b0;
            lt          <= 1'b0;
            unordered   <= 1'b0;
            pred_result <= 1'b0;
        end else if (in_valid) begin
            eq          <= eq_c;
            gt          <= gt_c;
            lt          <= lt_c;
            unordered   <= unord_c;
            pred_result <= pred_c;
        end
    end

endmodule

`default_nettype wire

// File: source/fp_minmax.sv
// Binary32 minNum and maxNum
`timescale 1ns/1ps
`default_nettype none

`include "fpcmp_params.svh"

module fp_minmax
    import fpcmp_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  fp32_t     fp_a,
    input  fp32_t     fp_b,
    input  fp_class_t a_class,
    input  fp_class_t b_class,
    output fp32_t     min_val,
    output fp32_t     max_val
);

    logic  a_nan;
    logic  b_nan;
    logic  mag_lt;
    logic  a_lt_b;
    fp32_t min_c;
    fp32_t max_c;

    assign a_nan = a_class[CLS_QNAN] | a_class[CLS_SNAN];
    assign b_nan = b_class[CLS_QNAN] | b_class[CLS_SNAN];

    // Sign first, so -0 sits below +0
    assign mag_lt = (fp_a[30:0] < fp_b[30:0]);
    assign a_lt_b = (fp_a[31] != fp_b[31]) ? fp_a[31] :
                    (fp_a[31] ? (fp_b[30:0] < fp_a[30:0]) : mag_lt);

    always_comb begin
        if (a_nan && b_nan) begin
            min_c = `FPCMP_CANON_NAN;
            max_c = `FPCMP_CANON_NAN;
        end else if (a_nan) begin
            min_c = fp_b;  // A lone NaN loses to the number
            max_c = fp_b;
        end else if (b_nan) begin
            min_c = fp_a;
            max_c = fp_a;
        end else begin
            min_c = a_lt_b ? fp_a : fp_b;
            max_c = a_lt_b ? fp_b : fp_a;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            min_val <= '0;
            max_val <= '0;
        end else if (in_valid) begin
            min_val <= min_c;
            max_val <= max_c;
        end
    end

endmodule

`default_nettype wire

// File: source/fpcmp_regs.sv
// Compare unit control and status registers
`timescale 1ns/1ps
`default_nettype none

`include "fpcmp_params.svh"

module fpcmp_regs
    import fpcmp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_wr,
    input  logic [1:0]              cfg_addr,
    input  logic [`FPCMP_CFG_W-1:0] cfg_wdata,
    input  logic                    invalid_pulse,
    output logic [`FPCMP_CFG_W-1:0] cfg_rdata,
    output pred_sel_t               pred_sel,
    output logic                    signaling,
    output logic                    invalid_flag
);

    logic ctrl_wr;
    logic status_wr;

    assign ctrl_wr   = cfg_wr && (cfg_addr == `FPCMP_ADDR_CTRL);
    assign status_wr = cfg_wr && (cfg_addr == `FPCMP_ADDR_STATUS);

    // CTRL register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_sel  <= `FPCMP_PRED_EQ;
            signaling <= 1'b0;
        end else if (ctrl_wr) begin
            pred_sel  <= cfg_wdata[2:0];
            signaling <= cfg_wdata[3];
        end
    end

    // Sticky invalid, set beats write-1-to-clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            invalid_flag <= 1'b0;
        end else if (invalid_pulse) begin
            invalid_flag <= 1'b1;
        end else if (status_wr && cfg_wdata[0]) begin
            invalid_flag <= 1'b0;
        end
    end

    always_comb begin
        cfg_rdata = '0;  // Unmapped reads return zero
        case (cfg_addr)
            `FPCMP_ADDR_CTRL: begin
                cfg_rdata[2:0] = pred_sel;
                cfg_rdata[3]   = signaling;
            end
            `FPCMP_ADDR_STATUS: begin
                cfg_rdata[0] = invalid_flag;
            end
            default: begin
                cfg_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/fpcmp_top.sv
// Float compare unit top level
`timescale 1ns/1ps
`default_nettype none

`include "fpcmp_params.svh"

module fpcmp_top
    import fpcmp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_wr,
    input  logic [1:0]              cfg_addr,
    input  logic [`FPCMP_CFG_W-1:0] cfg_wdata,
    output logic [`FPCMP_CFG_W-1:0] cfg_rdata,
    input  fp32_t                   fp_a,
    input  fp32_t                   fp_b,
    input  logic                    in_valid,
    output logic                    out_valid,
    output logic                    eq,
    output logic                    gt,
    output logic                    lt,
    output logic                    unordered,
    output logic                    pred_result,
    output fp32_t                   min_val,
    output fp32_t                   max_val,
    output logic                    invalid_flag
);

    fp_class_t a_class;
    fp_class_t b_class;
    pred_sel_t pred_sel;
    logic      signaling;
    logic      invalid_pulse;

    fp_classifier a_class_i (
        .operand  (fp_a),
        .op_class (a_class)
    );

    fp_classifier b_class_i (
        .operand  (fp_b),
        .op_class (b_class)
    );

    fp_comparator cmp_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .fp_a          (fp_a),
        .fp_b          (fp_b),
        .a_class       (a_class),
        .b_class       (b_class),
        .pred_sel      (pred_sel),
        .signaling     (signaling),
        .out_valid     (out_valid),
        .eq            (eq),
        .gt            (gt),
        .lt            (lt),
        .unordered     (unordered),
        .pred_result   (pred_result),
        .invalid_pulse (invalid_pulse)
    );

    fp_minmax minmax_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .fp_a     (fp_a),
        .fp_b     (fp_b),
        .a_class  (a_class),
        .b_class  (b_class),
        .min_val  (min_val),
        .max_val  (max_val)
    );

    fpcmp_regs regs_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .invalid_pulse (invalid_pulse),
        .cfg_rdata     (cfg_rdata),
        .pred_sel      (pred_sel),
        .signaling     (signaling),
        .invalid_flag  (invalid_flag)
    );

endmodule

`default_nettype wire

// File: verification/fpcmp_asserts.sv
// Compare unit reference checks
`timescale 1ns/1ps
`default_nettype none

`include "fpcmp_params.svh"

module fpcmp_asserts
    import fpcmp_pkg::*;
(
    input logic                    clk,
    input logic                    rst_n,
    input logic                    cfg_wr,
    input logic [1:0]              cfg_addr,
    input logic [`FPCMP_CFG_W-1:0] cfg_wdata,
    input logic [`FPCMP_CFG_W-1:0] cfg_rdata,
    input fp32_t                   fp_a,
    input fp32_t                   fp_b,
    input logic                    in_valid,
    input logic                    out_valid,
    input logic                    eq,
    input logic                    gt,
    input logic                    lt,
    input logic                    unordered,
    input logic                    pred_result,
    input fp32_t                   min_val,
    input fp32_t                   max_val,
    input logic                    invalid_flag
);

    int                      fail_count = 0;
    pred_sel_t               m_code;
    logic                    m_sig;
    logic                    m_valid;
    logic                    m_pulse;
    logic                    m_flag;
    logic [3:0]              m_rel;    // {eq, gt, lt, unordered}
    logic                    m_res;
    fp32_t                   m_min;
    fp32_t                   m_max;
    logic [3:0]              rel_c;
    logic [63:0]             mm_c;
    logic [`FPCMP_CFG_W-1:0] m_rdata;

    function automatic logic is_nan(fp32_t x);
        return (x[30:23] == 8'hFF) && (x[22:0] != 23'h0);
    endfunction

    function automatic logic is_snan(fp32_t x);
        return is_nan(x) && !x[22];
    endfunction

    // Unsigned key that rises with the value, -0 just below +0
    function automatic logic [31:0] order_key(fp32_t x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic [3:0] relation(fp32_t a, fp32_t b);
        logic [31:0] ka;
        logic [31:0] kb;
        ka = order_key((a[30:0] == 31'h0) ? 32'h0 : a);  // Both zeros fold to +0
        kb = order_key((b[30:0] == 31'h0) ? 32'h0 : b);
        if (is_nan(a) || is_nan(b)) begin
            return 4'b0001;
        end else if (ka == kb) begin
            return 4'b1000;
        end
        return (ka > kb) ? 4'b0100 : 4'b0010;
    endfunction

    function automatic logic predicate(pred_sel_t code, logic [3:0] r);
        case (code)
            `FPCMP_PRED_EQ: return r[3];
            `FPCMP_PRED_NE: return !r[3];
            `FPCMP_PRED_LT: return r[1];
            `FPCMP_PRED_LE: return r[1] | r[3];
            `FPCMP_PRED_GT: return r[2];
            `FPCMP_PRED_GE: return r[2] | r[3];
            `FPCMP_PRED_UN: return r[0];
            default:        return !r[0];  // OR
        endcase
    endfunction

    function automatic logic [63:0] min_max(fp32_t a, fp32_t b);
        if (is_nan(a) && is_nan(b)) begin
            return {`FPCMP_CANON_NAN, `FPCMP_CANON_NAN};
        end else if (is_nan(a)) begin
            return {b, b};
        end else if (is_nan(b)) begin
            return {a, a};
        end
        return (order_key(a) < order_key(b)) ? {a, b} : {b, a};
    endfunction

    assign rel_c = relation(fp_a, fp_b);
    assign mm_c  = min_max(fp_a, fp_b);

    // Reference state, one stage behind the inputs like the DUT
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_code  <= `FPCMP_PRED_EQ;
            m_sig   <= 1'b0;
            m_valid <= 1'b0;
            m_pulse <= 1'b0;
            m_flag  <= 1'b0;
            m_rel   <= '0;
            m_res   <= 1'b0;
            m_min   <= '0;
            m_max   <= '0;
        end else begin
            if (cfg_wr && (cfg_addr == `FPCMP_ADDR_CTRL)) begin
                m_code <= cfg_wdata[2:0];
                m_sig  <= cfg_wdata[3];
            end
            if (m_pulse) begin
                m_flag <= 1'b1;
            end else if (cfg_wr && (cfg_addr == `FPCMP_ADDR_STATUS) && cfg_wdata[0]) begin
                m_flag <= 1'b0;
            end
            m_valid <= in_valid;
            m_pulse <= in_valid && (is_snan(fp_a) || is_snan(fp_b) ||
                                    (m_sig && (is_nan(fp_a) || is_nan(fp_b))));
            if (in_valid) begin
                m_rel <= rel_c;
                m_res <= predicate(m_code, rel_c);
                m_min <= mm_c[63:32];
                m_max <= mm_c[31:0];
            end
        end
    end

    always_comb begin
        m_rdata = '0;
        if (cfg_addr == `FPCMP_ADDR_CTRL) begin
            m_rdata[3:0] = {m_sig, m_code};
        end else if (cfg_addr == `FPCMP_ADDR_STATUS) begin
            m_rdata[0] = m_flag;
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n) out_valid == m_valid)
        else begin
            fail_count++;
            $error("CHECK FAILED out_valid: got %h expected %h",
                   $sampled(out_valid), $sampled(m_valid));
        end

    a_flags: assert property (@(posedge clk) disable iff (!rst_n)
                              {eq, gt, lt, unordered} == m_rel)
        else begin
            fail_count++;
            $error("CHECK FAILED eq/gt/lt/unordered: got %h expected %h",
                   $sampled({eq, gt, lt, unordered}), $sampled(m_rel));
        end

    a_pred: assert property (@(posedge clk) disable iff (!rst_n) pred_result == m_res)
        else begin
            fail_count++;
            $error("CHECK FAILED pred_result: got %h expected %h",
                   $sampled(pred_result), $sampled(m_res));
        end

    a_minmax: assert property (@(posedge clk) disable iff (!rst_n)
                               (min_val == m_min) && (max_val == m_max))
        else begin
            fail_count++;
            $error("CHECK FAILED min_val/max_val: got %h %h expected %h %h",
                   $sampled(min_val), $sampled(max_val), $sampled(m_min), $sampled(m_max));
        end

    a_flag: assert property (@(posedge clk) disable iff (!rst_n) invalid_flag == m_flag)
        else begin
            fail_count++;
            $error("CHECK FAILED invalid_flag: got %h expected %h",
                   $sampled(invalid_flag), $sampled(m_flag));
        end

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n) cfg_rdata == m_rdata)
        else begin
            fail_count++;
            $error("CHECK FAILED cfg_rdata: got %h expected %h",
                   $sampled(cfg_rdata), $sampled(m_rdata));
        end

endmodule

`default_nettype wire

// File: verification/fpcmp_tb.sv
// Float compare unit testbench
`timescale 1ns/1ps
`default_nettype none

`include "fpcmp_params.svh"

module fpcmp_tb
    import fpcmp_pkg::*;
();

    logic                    clk;
    logic                    rst_n;
    logic                    cfg_wr;
    logic [1:0]              cfg_addr;
    logic [`FPCMP_CFG_W-1:0] cfg_wdata;
    logic [`FPCMP_CFG_W-1:0] cfg_rdata;
    fp32_t                   fp_a;
    fp32_t                   fp_b;
    logic                    in_valid;
    logic                    out_valid;
    logic                    eq;
    logic                    gt;
    logic                    lt;
    logic                    unordered;
    logic                    pred_result;
    fp32_t                   min_val;
    fp32_t                   max_val;
    logic                    invalid_flag;
    int                      seed;

    // Zeros, infinities, NaNs, subnormals, extreme normals, then +1 and -1
    fp32_t specials [16] = '{
        32'h00000000, 32'h80000000, 32'h7F800000, 32'hFF800000,
        32'h7FC00000, 32'hFFC00001, 32'h7F800001, 32'hFFA00000,
        32'h00000001, 32'h807FFFFF, 32'h00800000, 32'h80800000,
        32'h7F7FFFFF, 32'hFF7FFFFF, 32'h3F800000, 32'hBF800000
    };

    fpcmp_top dut_i (.*);

    bind fpcmp_top fpcmp_asserts chk_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Any failed assertion ends the run
    always @(posedge clk) begin
        if (dut_i.chk_i.fail_count != 0) begin
            $display("Test failures found");
            $fatal(1, "A reference check failed, see the error above");
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [`FPCMP_CFG_W-1:0] data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    task automatic wait_result();
        int waited;
        waited = 0;
        while (!out_valid) begin
            if (waited == 8) begin
                $display("Test failures found");
                $fatal(1, "Timed out waiting for out_valid");
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    task automatic pick_operand(output fp32_t v);
        int r;
        r = $random(seed);
        if (r[1:0] == 2'b00) begin
            v = specials[r[5:2]];
        end else begin
            v = $random(seed);
        end
    endtask

    // All special pairs back to back under one CTRL setting
    task automatic sweep_specials(input logic [`FPCMP_CFG_W-1:0] ctrl);
        cfg_write(`FPCMP_ADDR_CTRL, ctrl);
        cfg_addr = `FPCMP_ADDR_STATUS;
        for (int i = 0; i < 16; i++) begin
            for (int j = 0; j < 16; j++) begin
                fp_a     = specials[i];
                fp_b     = specials[j];
                in_valid = 1'b1;
                next_cycle();
            end
        end
        in_valid = 1'b0;
        fp_a     = $random(seed);  // Idle operands must not reach the outputs
        wait_result();
        next_cycle();
        cfg_write(`FPCMP_ADDR_STATUS, 8'h00);  // Zero leaves the flag set
        cfg_write(`FPCMP_ADDR_STATUS, 8'h01);
    endtask

    task automatic run_random(input int cycles);
        int r;
        for (int n = 0; n < cycles; n++) begin
            r        = $random(seed);
            in_valid = (r[1:0] != 2'b00);
            pick_operand(fp_a);
            case (r[3:2])
                2'd0:    fp_b = fp_a;
                2'd1:    fp_b = {fp_a[31:23], 23'($random(seed))};  // Mantissa decides
                default: pick_operand(fp_b);
            endcase
            cfg_wr    = (r[7:4] == 4'h0);
            cfg_addr  = r[9:8];   // Includes unmapped addresses
            cfg_wdata = r[17:10];
            next_cycle();
        end
    endtask

    initial begin
        seed      = 64173;
        rst_n     = 1'b0;
        cfg_wr    = 1'b0;
        cfg_addr  = `FPCMP_ADDR_CTRL;  // CTRL read back right after reset
        cfg_wdata = '0;
        fp_a      = '0;
        fp_b      = '0;
        in_valid  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        for (int mode = 0; mode < 2; mode++) begin
            for (int code = 0; code < 8; code++) begin
                sweep_specials({4'b0000, mode[0], code[2:0]});
            end
        end
        run_random(4000);
        in_valid = 1'b0;
        cfg_wr   = 1'b0;
        repeat (3) next_cycle();
        if (dut_i.chk_i.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "Reference checks reported errors");
        end
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
source/fpcmp_pkg.sv
source/fp_classifier.sv
source/fp_comparator.sv
source/fp_minmax.sv
source/fpcmp_regs.sv
source/fpcmp_top.sv
verification/fpcmp_asserts.sv
verification/fpcmp_tb.sv

// File: Bender.yml
package:
  name: fpcmp

sources:
  - include_dirs:
      - include
    files:
      - source/fpcmp_pkg.sv
      - source/fp_classifier.sv
      - source/fp_comparator.sv
      - source/fp_minmax.sv
      - source/fpcmp_regs.sv
      - source/fpcmp_top.sv
      - target: simulation
        files:
          - verification/fpcmp_asserts.sv
          - verification/fpcmp_tb.sv
